// ==== Makefile ====
# Verilator build and run for the ASIC testbench

VERILATOR ?= verilator
TOP       ?= asic_tb
FILELIST  ?= asic.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) verification/asic_tb_model.svh

.PHONY: compile run clean

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== asic.f ====
+incdir+verification
source/asic_pkg.sv
source/video_timing.sv
source/io_ports.sv
source/memory_pager.sv
source/contention.sv
source/asic.sv
verification/asic_tb.sv

// ==== source/asic.sv ====
`timescale 1ns/100ps

module asic
    import asic_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,
    input  logic        ear,
    input  logic [7:0]  keyboard,
    output logic [7:0]  data_to_cpu,
    output logic        data_enable_n,
    output logic        wait_n,
    output logic [18:0] cpuramaddr,
    output logic        romcs_n,
    output logic        ramcs_n,
    output logic        ramwr_n,
    output logic        asic_is_using_ram,
    output logic        mic,
    output logic        beep,
    output logic        rdmsel,
    output sync_t       sync,
    output logic        int_n
);

    beam_t      beam;
    vmpr_t      vmpr;
    lmpr_t      lmpr;
    hmpr_t      hmpr;
    logic [7:0] lineint;
    logic       vint_n;
    logic       rint_n;
    logic       screen_off;
    logic       rom_access;

    ////////////////////////////////////////////////////////////////////////////
    // Video timing and interrupts
    video_timing video_timing_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .lineint (lineint),
        .beam    (beam),
        .sync    (sync),
        .vint_n  (vint_n),
        .rint_n  (rint_n)
    );

    assign int_n = vint_n & rint_n;

    ////////////////////////////////////////////////////////////////////////////
    // CPU side
    io_ports io_ports_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu           (cpu),
        .vint_n        (vint_n),
        .rint_n        (rint_n),
        .ear           (ear),
        .keyboard      (keyboard),
        .vmpr          (vmpr),
        .lmpr          (lmpr),
        .hmpr          (hmpr),
        .lineint       (lineint),
        .screen_off    (screen_off),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n),
        .mic           (mic),
        .beep          (beep),
        .rdmsel        (rdmsel)
    );

    memory_pager memory_pager_inst (
        .cpu        (cpu),
        .lmpr       (lmpr),
        .hmpr       (hmpr),
        .romcs_n    (romcs_n),
        .ramcs_n    (ramcs_n),
        .ramwr_n    (ramwr_n),
        .cpuramaddr (cpuramaddr),
        .rom_access (rom_access)
    );

    contention contention_inst (
        .cpu               (cpu),
        .beam              (beam),
        .vmpr              (vmpr),
        .screen_off        (screen_off),
        .rom_access        (rom_access),
        .wait_n            (wait_n),
        .asic_is_using_ram (asic_is_using_ram)
    );

endmodule

// ==== source/asic_pkg.sv ====
package asic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Raster geometry, in pixel clocks and lines
    localparam logic [9:0] h_total     = 10'd768;
    localparam logic [8:0] v_total     = 9'd312;
    localparam logic [9:0] hsync_start = 10'd80;
    localparam logic [9:0] hsync_end   = 10'd144;
    localparam logic [8:0] vsync_start = 9'd244;
    localparam logic [8:0] vsync_end   = 9'd248;
    localparam logic [8:0] v_active    = 9'd192;
    localparam logic [9:0] fetch_start = 10'd256;

    // Interrupt windows
    localparam logic [8:0] vint_line    = 9'd251;
    localparam logic [9:0] vint_h_start = 10'd224;
    localparam logic [9:0] vint_h_end   = 10'd480;
    localparam logic [9:0] rint_h_start = 10'd16;
    localparam logic [9:0] rint_h_end   = 10'd272;

    ////////////////////////////////////////////////////////////////////////////
    // I/O port numbers, decoded on the low address byte
    localparam logic [7:0] port_border  = 8'd254;
    localparam logic [7:0] port_vmpr    = 8'd252;
    localparam logic [7:0] port_hmpr    = 8'd251;
    localparam logic [7:0] port_lmpr    = 8'd250;
    localparam logic [7:0] port_lineint = 8'd249;
    localparam logic [7:0] port_status  = 8'd249;
    // High address byte that selects the keyboard rows
    localparam logic [7:0] port_kbd_row = 8'd255;

    // 16K section boundaries of the CPU address space
    localparam logic [15:0] section_b_base = 16'h4000;
    localparam logic [15:0] section_c_base = 16'h8000;
    localparam logic [15:0] section_d_base = 16'hC000;

    ////////////////////////////////////////////////////////////////////////////
    // Bundled types
    typedef struct packed {
        logic        mreq_n;
        logic        iorq_n;
        logic        rd_n;
        logic        wr_n;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic [9:0] hc;
        logic [8:0] vc;
    } beam_t;

    typedef struct packed {
        logic       unused;
        logic [1:0] mode;
        logic [4:0] page;
    } vmpr_t;

    typedef struct packed {
        logic       write_protect_a;
        logic       rom_d;
        logic       rom_a_off;
        logic [4:0] low_page;
    } lmpr_t;

    typedef struct packed {
        logic       external_mem;
        logic [1:0] mode3_clut;
        logic [4:0] high_page;
    } hmpr_t;

    typedef struct packed {
        logic csync;
        logic hsync;
        logic vsync;
    } sync_t;

endpackage

// ==== source/contention.sv ====
`timescale 1ns/100ps

module contention
    import asic_pkg::*;
(
    input  cpu_bus_t cpu,
    input  beam_t    beam,
    input  vmpr_t    vmpr,
    input  logic     screen_off,
    input  logic     rom_access,
    output logic     wait_n,
    output logic     asic_is_using_ram
);

    logic fetching;
    logic slot_busy;
    logic mem_contention;
    logic io_contention;
    logic io_cycle;

    // Pixel fetch window, from beam position and screen mode only
    assign fetching = (beam.vc < v_active) && (beam.hc >= fetch_start) && !screen_off;

    // First 10 clocks of every 16 belong to the video side
    assign slot_busy = beam.hc[3:0] < 4'd10;

    ////////////////////////////////////////////////////////////////////////////
    // Contention windows
    assign mem_contention = slot_busy |
                            ((vmpr.mode == 2'd0) && slot_busy &&
                             ((beam.hc < 10'd128) || (beam.hc >= fetch_start)));

    always_comb begin
        if (screen_off) begin
            io_contention = (beam.hc[3:0] == 4'd0) || (beam.hc[3:0] == 4'd1) ||
                            (beam.hc[3:0] == 4'd8) || (beam.hc[3:0] == 4'd9);
        end else begin
            io_contention = slot_busy;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wait generation, ROM accesses run free
    assign io_cycle = ~cpu.iorq_n & (~cpu.rd_n | ~cpu.wr_n);

    assign wait_n = ~((~cpu.mreq_n & mem_contention & ~rom_access) |
                      (io_cycle & io_contention));

    assign asic_is_using_ram = mem_contention & fetching;

endmodule

// ==== source/io_ports.sv ====
`timescale 1ns/100ps

module io_ports
    import asic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_bus_t   cpu,
    input  logic       vint_n,
    input  logic       rint_n,
    input  logic       ear,
    input  logic [7:0] keyboard,
    output vmpr_t      vmpr,
    output lmpr_t      lmpr,
    output hmpr_t      hmpr,
    output logic [7:0] lineint,
    output logic       screen_off,
    output logic [7:0] data_to_cpu,
    output logic       data_enable_n,
    output logic       mic,
    output logic       beep,
    output logic       rdmsel
);

    logic [7:0] border;
    logic [7:0] port;
    logic       io_write;
    logic       io_read;

    assign port     = cpu.addr[7:0];
    assign io_write = ~cpu.iorq_n & ~cpu.wr_n;
    assign io_read  = ~cpu.iorq_n & ~cpu.rd_n;

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            border  <= '0;
            vmpr    <= '0;
            lmpr    <= '0;
            hmpr    <= '0;
            lineint <= 8'hFF;
        end else if (io_write) begin
            case (port)
                port_border:  border  <= cpu.wdata;
                port_vmpr:    vmpr    <= cpu.wdata;
                port_hmpr:    hmpr    <= cpu.wdata;
                port_lmpr:    lmpr    <= cpu.wdata;
                port_lineint: lineint <= cpu.wdata;
                default:      ;
            endcase
        end
    end

    // Screen blanks only in modes 3 and 4
    assign screen_off = border[7] & vmpr.mode[1];

    assign mic    = border[3];
    assign beep   = border[4];
    assign rdmsel = (cpu.addr[15:8] != port_kbd_row);

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    always_comb begin
        data_to_cpu   = 8'hFF;
        data_enable_n = 1'b1;
        if (io_read) begin
            data_enable_n = 1'b0;
            case (port)
                port_border: data_to_cpu = {screen_off, ear, 1'b0, keyboard[4:0]};
                port_status: data_to_cpu = {keyboard[7:5], 1'b1, vint_n, 2'b11, rint_n};
                port_vmpr:   data_to_cpu = vmpr;
                port_hmpr:   data_to_cpu = hmpr;
                port_lmpr:   data_to_cpu = lmpr;
                default: begin
                    // Unmapped port, bus left to the pull-ups
                    data_to_cpu   = 8'hFF;
                    data_enable_n = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== source/memory_pager.sv ====
`timescale 1ns/100ps

module memory_pager
    import asic_pkg::*;
(
    input  cpu_bus_t    cpu,
    input  lmpr_t       lmpr,
    input  hmpr_t       hmpr,
    output logic        romcs_n,
    output logic        ramcs_n,
    output logic        ramwr_n,
    output logic [18:0] cpuramaddr,
    output logic        rom_access
);

    logic       in_a;
    logic       in_upper;
    logic       in_d;
    logic       rom_hit;
    logic [4:0] page;

    assign in_a     = cpu.addr < section_b_base;
    assign in_upper = cpu.addr >= section_c_base;
    assign in_d     = cpu.addr >= section_d_base;

    ////////////////////////////////////////////////////////////////////////////
    // Chip selects
    assign rom_hit    = (in_a & ~lmpr.rom_a_off) | (in_d & lmpr.rom_d);
    assign rom_access = ~cpu.mreq_n & rom_hit;
    assign romcs_n    = ~rom_access;

    // External memory takes over sections C and D
    assign ramcs_n = cpu.mreq_n | rom_hit | (in_upper & hmpr.external_mem);

    assign ramwr_n = ramcs_n | cpu.wr_n | (in_a & lmpr.write_protect_a);

    ////////////////////////////////////////////////////////////////////////////
    // Page per 16K section
    always_comb begin
        case (cpu.addr[15:14])
            2'b00:   page = lmpr.low_page;
            2'b01:   page = lmpr.low_page + 5'd1;
            2'b10:   page = hmpr.high_page;
            default: page = hmpr.high_page + 5'd1;
        endcase
    end

    assign cpuramaddr = {page, cpu.addr[13:0]};

endmodule

// ==== source/video_timing.sv ====
`timescale 1ns/100ps

module video_timing
    import asic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] lineint,
    output beam_t      beam,
    output sync_t      sync,
    output logic       vint_n,
    output logic       rint_n
);

    logic [9:0] hc;
    logic [8:0] vc;
    logic       in_hsync;
    logic       in_vsync;
    logic       line_match;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel clock and line counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (hc == h_total - 10'd1) begin
            hc <= '0;
            if (vc == v_total - 9'd1) begin
                vc <= '0;
            end else begin
                vc <= vc + 9'd1;
            end
        end else begin
            hc <= hc + 10'd1;
        end
    end

    assign beam.hc = hc;
    assign beam.vc = vc;

    ////////////////////////////////////////////////////////////////////////////
    // Syncs, all active low
    assign in_hsync = (hc >= hsync_start) && (hc < hsync_end);
    assign in_vsync = (vc >= vsync_start) && (vc < vsync_end);

    assign sync.hsync = ~in_hsync;
    assign sync.vsync = ~in_vsync;
    // Composite sync flips polarity for the vsync lines
    assign sync.csync = in_vsync ? in_hsync : ~in_hsync;

    ////////////////////////////////////////////////////////////////////////////
    // Frame and line interrupts
    assign vint_n = ~((vc == vint_line) && (hc >= vint_h_start) && (hc < vint_h_end));

    // Lines past the active area never raise a line interrupt
    assign line_match = ({1'b0, lineint} < v_active) && (vc == {1'b0, lineint});
    assign rint_n = ~(line_match && (hc >= rint_h_start) && (hc < rint_h_end));

endmodule

// ==== verification/asic_tb_model.svh ====
`ifndef asic_tb_model_svh
`define asic_tb_model_svh

////////////////////////////////////////////////////////////////////////////
// Raster and interrupts

function automatic sync_t sync_shape(input logic [9:0] hc, input logic [8:0] vc);
    sync_t s;
    logic  v_low;
    v_low   = (vc >= vsync_start) && (vc < vsync_end);
    s.hsync = !((hc >= hsync_start) && (hc < hsync_end));
    s.vsync = !v_low;
    // Composite is hsync, inverted on vsync lines
    s.csync = s.hsync ^ v_low;
    return s;
endfunction

function automatic logic frame_irq_n(input logic [9:0] hc, input logic [8:0] vc);
    return !((vc == vint_line) && (hc >= vint_h_start) && (hc < vint_h_end));
endfunction

function automatic logic line_irq_n(input logic [9:0] hc, input logic [8:0] vc,
                                    input logic [7:0] lineint);
    if (lineint > 8'd191) begin
        return 1'b1;
    end
    return !((vc == {1'b0, lineint}) && (hc >= rint_h_start) && (hc < rint_h_end));
endfunction

////////////////////////////////////////////////////////////////////////////
// Memory paging

function automatic logic rom_hit_at(input logic [15:0] addr, input lmpr_t lmpr);
    return ((addr[15:14] == 2'd0) && !lmpr.rom_a_off) || ((addr[15:14] == 2'd3) && lmpr.rom_d);
endfunction

function automatic logic [18:0] ram_address(input logic [15:0] addr, input lmpr_t lmpr,
                                            input hmpr_t hmpr);
    logic [4:0] page;
    case (addr[15:14])
        2'd0:    page = lmpr.low_page;
        2'd1:    page = lmpr.low_page + 5'd1;
        2'd2:    page = hmpr.high_page;
        default: page = hmpr.high_page + 5'd1;
    endcase
    return {page, addr[13:0]};
endfunction

// Returns ramcs_n, ramwr_n
function automatic logic [1:0] ram_strobes_n(input cpu_bus_t bus, input lmpr_t lmpr,
                                             input hmpr_t hmpr);
    logic cs_n;
    logic wr_n;
    cs_n = bus.mreq_n || rom_hit_at(bus.addr, lmpr) || (bus.addr[15] && hmpr.external_mem);
    wr_n = cs_n || bus.wr_n || ((bus.addr[15:14] == 2'd0) && lmpr.write_protect_a);
    return {cs_n, wr_n};
endfunction

////////////////////////////////////////////////////////////////////////////
// Contention

function automatic logic mem_busy_at(input logic [9:0] hc, input logic [1:0] mode);
    logic slot;
    slot = hc[3:0] < 4'd10;
    return slot || ((mode == 2'd0) && slot && ((hc < 10'd128) || (hc >= 10'd256)));
endfunction

function automatic logic fetch_busy(input logic [9:0] hc, input logic [8:0] vc,
                                    input logic [1:0] mode, input logic screen_off);
    return mem_busy_at(hc, mode) && (vc < 9'd192) && (hc >= 10'd256) && !screen_off;
endfunction

function automatic logic wait_state_n(input cpu_bus_t bus, input logic [9:0] hc,
                                      input logic [1:0] mode, input logic screen_off,
                                      input logic rom_cycle);
    logic io_busy;
    if (screen_off) begin
        io_busy = (hc[3:0] == 4'd0) || (hc[3:0] == 4'd1) ||
                  (hc[3:0] == 4'd8) || (hc[3:0] == 4'd9);
    end else begin
        io_busy = hc[3:0] < 4'd10;
    end
    return !((!bus.mreq_n && mem_busy_at(hc, mode) && !rom_cycle) ||
             (!bus.iorq_n && (!bus.rd_n || !bus.wr_n) && io_busy));
endfunction

////////////////////////////////////////////////////////////////////////////
// Port reads, returns data_enable_n and the data byte

function automatic logic [8:0] port_readback(input cpu_bus_t bus, input logic [7:0] border,
                                             input vmpr_t vmpr, input lmpr_t lmpr,
                                             input hmpr_t hmpr, input logic ear,
                                             input logic [7:0] kbd, input logic vint_n,
                                             input logic rint_n);
    if (bus.iorq_n || bus.rd_n) begin
        return {1'b1, 8'hFF};
    end
    case (bus.addr[7:0])
        port_border: return {1'b0, border[7] & vmpr.mode[1], ear, 1'b0, kbd[4:0]};
        port_status: return {1'b0, kbd[7:5], 1'b1, vint_n, 1'b1, 1'b1, rint_n};
        port_vmpr:   return {1'b0, vmpr};
        port_hmpr:   return {1'b0, hmpr};
        port_lmpr:   return {1'b0, lmpr};
        default:     return {1'b1, 8'hFF};
    endcase
endfunction

`endif

// ==== verification/asic_tb.sv ====
`timescale 1ns/100ps

module asic_tb
    import asic_pkg::*;
();

    localparam int frame_cycles = int'(h_total) * int'(v_total);
    localparam int irq_window   = int'(vint_h_end - vint_h_start);
    localparam int line_window  = int'(rint_h_end - rint_h_start);
    // Two and a half frames, the two timed frames plus register traffic and margin
    localparam int timeout_cycles = (5 * frame_cycles) / 2;

    logic        clk;
    logic        rst_n;
    cpu_bus_t    cpu;
    logic        ear;
    logic [7:0]  keyboard;
    logic [7:0]  data_to_cpu;
    logic        data_enable_n;
    logic        wait_n;
    logic [18:0] cpuramaddr;
    logic        romcs_n;
    logic        ramcs_n;
    logic        ramwr_n;
    logic        asic_is_using_ram;
    logic        mic;
    logic        beep;
    logic        rdmsel;
    sync_t       sync;
    logic        int_n;

    // Beam and register state as the testbench expects it
    logic [9:0]  beam_hc;
    logic [8:0]  beam_vc;
    logic [7:0]  shadow_border;
    vmpr_t       shadow_vmpr;
    lmpr_t       shadow_lmpr;
    hmpr_t       shadow_hmpr;
    logic [7:0]  shadow_lineint;

    logic        checking;
    string       test_name;
    integer      seed;
    int          cycle_count = 0;
    int          int_low_count = 0;
    logic [7:0]  last_data;
    logic        last_de_n;
    logic        last_rdmsel;

    `include "asic_tb_model.svh"

    asic asic_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .cpu               (cpu),
        .ear               (ear),
        .keyboard          (keyboard),
        .data_to_cpu       (data_to_cpu),
        .data_enable_n     (data_enable_n),
        .wait_n            (wait_n),
        .cpuramaddr        (cpuramaddr),
        .romcs_n           (romcs_n),
        .ramcs_n           (ramcs_n),
        .ramwr_n           (ramwr_n),
        .asic_is_using_ram (asic_is_using_ram),
        .mic               (mic),
        .beep              (beep),
        .rdmsel            (rdmsel),
        .sync              (sync),
        .int_n             (int_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beam counters and register writes, mirrored from the bus rules
    always @(posedge clk) begin
        if (!rst_n) begin
            beam_hc        <= '0;
            beam_vc        <= '0;
            shadow_border  <= '0;
            shadow_vmpr    <= '0;
            shadow_lmpr    <= '0;
            shadow_hmpr    <= '0;
            shadow_lineint <= 8'hFF;
        end else begin
            if (beam_hc == 10'd767) begin
                beam_hc <= '0;
                beam_vc <= (beam_vc == 9'd311) ? 9'd0 : beam_vc + 9'd1;
            end else begin
                beam_hc <= beam_hc + 10'd1;
            end
            if (!cpu.iorq_n && !cpu.wr_n) begin
                case (cpu.addr[7:0])
                    8'd254:  shadow_border  <= cpu.wdata;
                    8'd252:  shadow_vmpr    <= cpu.wdata;
                    8'd251:  shadow_hmpr    <= cpu.wdata;
                    8'd250:  shadow_lmpr    <= cpu.wdata;
                    8'd249:  shadow_lineint <= cpu.wdata;
                    default: ;
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else begin
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("sim failed");
            $fatal(1, "output mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare process, outputs are stable on the falling edge
    always @(negedge clk) begin : compare
        logic       vint_exp;
        logic       rint_exp;
        logic       rom_exp;
        logic       off_exp;
        logic [1:0] ram_exp;
        logic [8:0] read_exp;
        if (checking) begin
            vint_exp = frame_irq_n(beam_hc, beam_vc);
            rint_exp = line_irq_n(beam_hc, beam_vc, shadow_lineint);
            rom_exp  = !cpu.mreq_n && rom_hit_at(cpu.addr, shadow_lmpr);
            off_exp  = shadow_border[7] && shadow_vmpr.mode[1];
            ram_exp  = ram_strobes_n(cpu, shadow_lmpr, shadow_hmpr);
            read_exp = port_readback(cpu, shadow_border, shadow_vmpr, shadow_lmpr, shadow_hmpr,
                                     ear, keyboard, vint_exp, rint_exp);
            check_value("sync", 32'(sync_shape(beam_hc, beam_vc)), 32'(sync));
            check_value("int_n", 32'(vint_exp & rint_exp), 32'(int_n));
            check_value("romcs_n", 32'(!rom_exp), 32'(romcs_n));
            check_value("ramcs_n", 32'(ram_exp[1]), 32'(ramcs_n));
            check_value("ramwr_n", 32'(ram_exp[0]), 32'(ramwr_n));
            check_value("cpuramaddr", 32'(ram_address(cpu.addr, shadow_lmpr, shadow_hmpr)),
                        32'(cpuramaddr));
            check_value("wait_n",
                        32'(wait_state_n(cpu, beam_hc, shadow_vmpr.mode, off_exp, rom_exp)),
                        32'(wait_n));
            check_value("asic_is_using_ram",
                        32'(fetch_busy(beam_hc, beam_vc, shadow_vmpr.mode, off_exp)),
                        32'(asic_is_using_ram));
            check_value("data_enable_n", 32'(read_exp[8]), 32'(data_enable_n));
            check_value("data_to_cpu", 32'(read_exp[7:0]), 32'(data_to_cpu));
            check_value("mic", 32'(shadow_border[3]), 32'(mic));
            check_value("beep", 32'(shadow_border[4]), 32'(beep));
            check_value("rdmsel", 32'(cpu.addr[15:8] != 8'hFF), 32'(rdmsel));
            if (!int_n) begin
                int_low_count <= int_low_count + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // CPU bus driver

    function automatic cpu_bus_t bus_of(input logic mreq_n, input logic iorq_n,
                                        input logic rd_n, input logic wr_n,
                                        input logic [15:0] addr, input logic [7:0] wdata);
        cpu_bus_t b;
        b.mreq_n = mreq_n;
        b.iorq_n = iorq_n;
        b.rd_n   = rd_n;
        b.wr_n   = wr_n;
        b.addr   = addr;
        b.wdata  = wdata;
        return b;
    endfunction

    // One bus cycle, held until wait_n is seen high
    task automatic run_cycle(input cpu_bus_t b);
        cpu = b;
        @(negedge clk);
        while (!wait_n) @(negedge clk);
        last_data   = data_to_cpu;
        last_de_n   = data_enable_n;
        last_rdmsel = rdmsel;
        @(posedge clk);
        #1;
        cpu = bus_of(1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 8'h00);
    endtask

    task automatic write_port(input logic [7:0] port, input logic [7:0] data);
        run_cycle(bus_of(1'b1, 1'b0, 1'b1, 1'b0, {8'h00, port}, data));
    endtask

    task automatic read_port(input logic [15:0] addr);
        run_cycle(bus_of(1'b1, 1'b0, 1'b0, 1'b1, addr, 8'h00));
    endtask

    task automatic access_memory(input logic [15:0] addr, input logic is_write,
                                 input logic [7:0] data);
        run_cycle(bus_of(1'b0, 1'b1, is_write, !is_write, addr, data));
    endtask

    // Holds one cycle unchanged for a fixed number of clocks
    task automatic hold_bus(input cpu_bus_t b, input int clocks);
        cpu = b;
        repeat (clocks) @(posedge clk);
        #1;
        cpu = bus_of(1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 8'h00);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin : stimulus
        logic [31:0] value;
        logic [7:0]  vmpr_written;
        logic [7:0]  line;
        int          start;
        int          low_start;
        seed      = 60;
        checking  = 1'b0;
        test_name = "reset";
        rst_n     = 1'b0;
        ear       = 1'b0;
        keyboard  = 8'hFF;
        cpu       = bus_of(1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 8'h00);
        repeat (4) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        checking = 1'b1;

        // Contention on the first active lines, modes 0 and 3, screen on and off
        test_name = "contention";
        for (int i = 0; i < 4; i++) begin
            write_port(port_vmpr, {1'b0, (i[1] ? 2'd3 : 2'd0), 5'd0});
            write_port(port_border, {i[0], 7'd0});
            hold_bus(bus_of(1'b0, 1'b1, 1'b0, 1'b1, 16'h8000, 8'h00), int'(h_total));
            hold_bus(bus_of(1'b0, 1'b1, 1'b0, 1'b1, 16'h0100, 8'h00), int'(h_total));
            hold_bus(bus_of(1'b1, 1'b0, 1'b0, 1'b1, 16'h00FE, 8'h00), int'(h_total));
            hold_bus(bus_of(1'b1, 1'b0, 1'b1, 1'b0, 16'h0010, 8'h55), int'(h_total));
        end

        test_name = "registers";
        repeat (8) begin
            value = $random(seed);
            vmpr_written = value[7:0];
            write_port(port_vmpr, value[7:0]);
            read_port({8'h00, port_vmpr});
            check_value("vmpr_readback", 32'(value[7:0]), 32'(last_data));
            write_port(port_hmpr, value[15:8]);
            read_port({8'h00, port_hmpr});
            check_value("hmpr_readback", 32'(value[15:8]), 32'(last_data));
            write_port(port_lmpr, value[23:16]);
            read_port({8'h00, port_lmpr});
            check_value("lmpr_readback", 32'(value[23:16]), 32'(last_data));
        end
        value    = $random(seed);
        keyboard = value[15:8];
        ear      = value[16];
        write_port(port_border, value[7:0]);
        check_value("mic", 32'(value[3]), 32'(mic));
        check_value("beep", 32'(value[4]), 32'(beep));
        read_port({8'h00, port_border});
        check_value("border_read",
                    32'({value[7] & vmpr_written[6], value[16], 1'b0, value[12:8]}),
                    32'(last_data));
        read_port({8'h00, port_status});
        check_value("status_fixed_bits", 32'({value[15:13], 1'b1, 2'b11}),
                    32'({last_data[7:4], last_data[2:1]}));
        read_port(16'h0010);
        check_value("unmapped_data", 32'(8'hFF), 32'(last_data));
        check_value("unmapped_enable_n", 32'(1'b1), 32'(last_de_n));
        read_port(16'hFFFE);
        check_value("rdmsel_low", 32'(1'b0), 32'(last_rdmsel));
        read_port(16'h7FFE);
        check_value("rdmsel_high", 32'(1'b1), 32'(last_rdmsel));

        // Selects and address are checked on every clock by the compare process
        test_name = "paging";
        for (int i = 0; i < 200; i++) begin
            if (i % 5 == 0) begin
                value = $random(seed);
                write_port(port_lmpr, value[7:0]);
                write_port(port_hmpr, value[15:8]);
            end
            value = $random(seed);
            access_memory(value[15:0], value[16], value[31:24]);
        end

        // A line register past the active area leaves only the frame interrupt
        test_name = "sync_frame";
        write_port(port_lineint, 8'd200);
        low_start = int_low_count;
        repeat (frame_cycles) @(posedge clk);
        #1;
        check_value("int_low_cycles", 32'(irq_window), 32'(int_low_count - low_start));

        test_name = "interrupts";
        value = $random(seed);
        line  = value[7:0] % 8'd192;
        write_port(port_lineint, line);
        start     = cycle_count;
        low_start = int_low_count;
        while (cycle_count - start < frame_cycles - 32) begin
            read_port({8'h00, port_status});
        end
        while (cycle_count - start < frame_cycles) begin
            @(posedge clk);
            #1;
        end
        check_value("int_low_cycles", 32'(irq_window + line_window),
                    32'(int_low_count - low_start));

        $display("sim passed");
        $finish;
    end

endmodule
